//--- source/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data format and sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int DATA_W    = 16;              // Q8.8 word
    localparam int FRAC_BITS = 8;
    localparam int TAPS      = 9;               // 3x3 kernel
    localparam int TAP_W     = $clog2(TAPS);    // Tap counter width
    localparam int WIN_W     = TAPS * DATA_W;   // Packed window or weight bank
    localparam int ADDR_W    = 7;               // 128 words

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        CONV_IDLE,
        CONV_MULT,
        CONV_ACC1,      // Four pair sums
        CONV_ACC2,      // Two sums of sums
        CONV_ACC3,
        CONV_ACC4,      // Plus the ninth product
        CONV_FINISH
    } conv_state_e;

    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_WAIT,
        FETCH_CONV,
        FETCH_NEXT
    } fetch_state_e;

endpackage

`default_nettype wire

//--- source/fx_mult.sv
`timescale 1ns/1ps
`default_nettype none

module fx_mult (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic signed [conv_pkg::DATA_W-1:0] i_a,
    input  logic signed [conv_pkg::DATA_W-1:0] i_b,
    input  logic                               i_nd,
    output logic        [conv_pkg::DATA_W-1:0] o_result,
    output logic                               o_rdy
);
    import conv_pkg::*;

    localparam logic signed [2*DATA_W-1:0] SAT_MAX = 2**(DATA_W-1) - 1;
    localparam logic signed [2*DATA_W-1:0] SAT_MIN = -(2**(DATA_W-1));

    logic signed [2*DATA_W-1:0] prod;
    logic signed [2*DATA_W-1:0] scaled;

    assign prod   = i_a * i_b;
    assign scaled = prod >>> FRAC_BITS;     // Floors toward minus infinity

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rdy <= 1'b0;
        end else begin
            o_rdy <= i_nd;
        end
    end

    always_ff @(posedge clk) begin
        if (i_nd) begin
            if (scaled > SAT_MAX)
                o_result <= SAT_MAX[DATA_W-1:0];
            else if (scaled < SAT_MIN)
                o_result <= SAT_MIN[DATA_W-1:0];
            else
                o_result <= scaled[DATA_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- source/fx_add.sv
`timescale 1ns/1ps
`default_nettype none

module fx_add (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic signed [conv_pkg::DATA_W-1:0] i_a,
    input  logic signed [conv_pkg::DATA_W-1:0] i_b,
    input  logic                               i_nd,
    output logic        [conv_pkg::DATA_W-1:0] o_result,
    output logic                               o_rdy
);
    import conv_pkg::*;

    logic signed [DATA_W:0] sum;    // One guard bit

    assign sum = i_a + i_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rdy <= 1'b0;
        end else begin
            o_rdy <= i_nd;
        end
    end

    // Guard and sign bits disagree on overflow
    always_ff @(posedge clk) begin
        if (i_nd) begin
            if (sum[DATA_W] != sum[DATA_W-1])
                o_result <= sum[DATA_W] ? {1'b1, {(DATA_W-1){1'b0}}}
                                        : {1'b0, {(DATA_W-1){1'b1}}};
            else
                o_result <= sum[DATA_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- source/conv_3x3.sv
`timescale 1ns/1ps
`default_nettype none

module conv_3x3 (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [conv_pkg::WIN_W-1:0]  i_im,
    input  logic [conv_pkg::WIN_W-1:0]  i_iw,
    input  logic                        i_conv_ready,
    output logic [conv_pkg::DATA_W-1:0] o_om,
    output logic                        o_conv_valid
);
    import conv_pkg::*;

    conv_state_e       state;

    logic              mul_nd;
    logic [TAPS-1:0]   mul_rdy;
    logic [DATA_W-1:0] prod [TAPS];

    logic [3:0]        add_nd;
    logic [3:0]        add_rdy;
    logic [DATA_W-1:0] add_a [4];
    logic [DATA_W-1:0] add_b [4];
    logic [DATA_W-1:0] sum [4];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Arithmetic units
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar t = 0; t < TAPS; t++) begin : g_mult
        fx_mult u_mult (
            .clk      (clk),
            .rst_n    (rst_n),
            .i_a      (i_im[t*DATA_W +: DATA_W]),
            .i_b      (i_iw[t*DATA_W +: DATA_W]),
            .i_nd     (mul_nd),
            .o_result (prod[t]),
            .o_rdy    (mul_rdy[t])
        );
    end

    for (genvar k = 0; k < 4; k++) begin : g_add
        fx_add u_add (
            .clk      (clk),
            .rst_n    (rst_n),
            .i_a      (add_a[k]),
            .i_b      (add_b[k]),
            .i_nd     (add_nd[k]),
            .o_result (sum[k]),
            .o_rdy    (add_rdy[k])
        );
    end

    // Adder operands follow the stage
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            add_a[i] = prod[2*i];           // ACC1 pairing
            add_b[i] = prod[2*i+1];
        end
        case (state)
            CONV_ACC2: begin
                add_a[0] = sum[0];
                add_b[0] = sum[1];
                add_a[1] = sum[2];
                add_b[1] = sum[3];
            end
            CONV_ACC3: begin
                add_a[0] = sum[0];
                add_b[0] = sum[1];
            end
            CONV_ACC4: begin
                add_a[0] = sum[0];
                add_b[0] = prod[TAPS-1];
            end
            default: ;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= CONV_IDLE;
            mul_nd       <= 1'b0;
            add_nd       <= '0;
            o_conv_valid <= 1'b0;
        end else begin
            mul_nd       <= 1'b0;
            add_nd       <= '0;
            o_conv_valid <= 1'b0;
            case (state)
                CONV_IDLE: if (i_conv_ready) begin
                    mul_nd <= 1'b1;
                    state  <= CONV_MULT;
                end
                CONV_MULT: if (&mul_rdy) begin
                    add_nd <= 4'b1111;
                    state  <= CONV_ACC1;
                end
                CONV_ACC1: if (&add_rdy) begin
                    add_nd <= 4'b0011;
                    state  <= CONV_ACC2;
                end
                CONV_ACC2: if (&add_rdy[1:0]) begin
                    add_nd <= 4'b0001;
                    state  <= CONV_ACC3;
                end
                CONV_ACC3: if (add_rdy[0]) begin
                    add_nd <= 4'b0001;
                    state  <= CONV_ACC4;
                end
                CONV_ACC4: if (add_rdy[0]) begin
                    state <= CONV_FINISH;
                end
                CONV_FINISH: begin
                    o_conv_valid <= 1'b1;
                    state        <= CONV_IDLE;
                end
                default: state <= CONV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == CONV_FINISH)
            o_om <= sum[0];
    end

endmodule

`default_nettype wire

//--- source/pixel_mem.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_mem #(
    parameter int MEM_DEPTH = 128
) (
    input  logic                        clk,
    input  logic                        i_we,
    input  logic [conv_pkg::ADDR_W-1:0] i_addr,
    input  logic [conv_pkg::DATA_W-1:0] i_wdata,
    output logic [conv_pkg::DATA_W-1:0] o_rdata
);
    import conv_pkg::*;

    // Image, then weights, then spare words
    logic [DATA_W-1:0] mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (i_we)
            mem[i_addr] <= i_wdata;
        o_rdata <= mem[i_addr];     // Valid the cycle after the grant
    end

endmodule

`default_nettype wire

//--- source/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                        i_host_req,
    input  logic                        i_host_we,
    input  logic [conv_pkg::ADDR_W-1:0] i_host_addr,
    input  logic [conv_pkg::DATA_W-1:0] i_host_wdata,
    input  logic                        i_wl_req,
    input  logic [conv_pkg::ADDR_W-1:0] i_wl_addr,
    output logic                        o_wl_gnt,
    input  logic                        i_wf_req,
    input  logic [conv_pkg::ADDR_W-1:0] i_wf_addr,
    output logic                        o_wf_gnt,
    output logic                        o_mem_we,
    output logic [conv_pkg::ADDR_W-1:0] o_mem_addr,
    output logic [conv_pkg::DATA_W-1:0] o_mem_wdata
);
    localparam int HOST   = 0;
    localparam int WLOAD  = 1;
    localparam int WFETCH = 2;

    logic [2:0] req;
    logic [2:0] gnt;

    assign req = {i_wf_req, i_wl_req, i_host_req};
    assign gnt = req & (~req + 3'd1);      // Lowest index wins

    assign o_wl_gnt = gnt[WLOAD];
    assign o_wf_gnt = gnt[WFETCH];

    always_comb begin
        o_mem_addr = i_wf_addr;
        if (gnt[HOST])
            o_mem_addr = i_host_addr;
        else if (gnt[WLOAD])
            o_mem_addr = i_wl_addr;
    end

    // Only the host writes
    assign o_mem_we    = gnt[HOST] & i_host_we;
    assign o_mem_wdata = i_host_wdata;

endmodule

`default_nettype wire

//--- source/weight_load.sv
`timescale 1ns/1ps
`default_nettype none

module weight_load #(
    parameter int WEIGHT_BASE = 64
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_start,
    output logic                        o_req,
    output logic [conv_pkg::ADDR_W-1:0] o_addr,
    input  logic                        i_gnt,
    input  logic [conv_pkg::DATA_W-1:0] i_rdata,
    output logic [conv_pkg::WIN_W-1:0]  o_weights,
    output logic                        o_loaded,
    output logic                        o_busy
);
    import conv_pkg::*;

    logic [TAP_W-1:0] tap;          // Tap being requested
    logic [TAP_W-1:0] rd_tap;       // Tap whose word is on rdata
    logic             rd_pend;

    assign o_addr = ADDR_W'(WEIGHT_BASE) + ADDR_W'(tap);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_req    <= 1'b0;
            o_busy   <= 1'b0;
            o_loaded <= 1'b0;
            tap      <= '0;
            rd_tap   <= '0;
            rd_pend  <= 1'b0;
        end else begin
            o_loaded <= 1'b0;
            rd_pend  <= o_req & i_gnt;
            if (i_start && !o_busy) begin
                o_busy <= 1'b1;
                o_req  <= 1'b1;
                tap    <= '0;
            end
            if (o_req && i_gnt) begin
                rd_tap <= tap;
                if (tap == TAP_W'(TAPS - 1))
                    o_req <= 1'b0;
                else
                    tap <= tap + 1'b1;
            end
            if (rd_pend && rd_tap == TAP_W'(TAPS - 1))
                o_loaded <= 1'b1;
            if (o_loaded)
                o_busy <= 1'b0;     // Fetcher takes over busy here
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pend)
            o_weights[rd_tap*DATA_W +: DATA_W] <= i_rdata;
    end

endmodule

`default_nettype wire

//--- source/window_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module window_fetch #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_go,
    output logic                        o_req,
    output logic [conv_pkg::ADDR_W-1:0] o_addr,
    input  logic                        i_gnt,
    input  logic [conv_pkg::DATA_W-1:0] i_rdata,
    output logic [conv_pkg::WIN_W-1:0]  o_window,
    output logic                        o_conv_ready,
    input  logic                        i_conv_valid,
    output logic                        o_done,
    output logic                        o_busy
);
    import conv_pkg::*;

    fetch_state_e      state;
    logic [ADDR_W-1:0] row;         // Output position
    logic [ADDR_W-1:0] col;
    logic [1:0]        dx;          // Offset inside the window
    logic [1:0]        dy;
    logic [TAP_W-1:0]  tap;
    logic [TAP_W-1:0]  rd_tap;
    logic              rd_pend;

    assign o_req  = (state == FETCH_REQ);
    assign o_addr = ADDR_W'((row + dy) * IMG_W + col + dx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= FETCH_IDLE;
            row          <= '0;
            col          <= '0;
            dx           <= '0;
            dy           <= '0;
            tap          <= '0;
            rd_tap       <= '0;
            rd_pend      <= 1'b0;
            o_conv_ready <= 1'b0;
            o_done       <= 1'b0;
            o_busy       <= 1'b0;
        end else begin
            rd_pend      <= o_req & i_gnt;
            o_conv_ready <= 1'b0;
            o_done       <= 1'b0;
            case (state)
                FETCH_IDLE: if (i_go) begin
                    row    <= '0;
                    col    <= '0;
                    dx     <= '0;
                    dy     <= '0;
                    tap    <= '0;
                    o_busy <= 1'b1;
                    state  <= FETCH_REQ;
                end
                FETCH_REQ: if (i_gnt) begin
                    rd_tap <= tap;
                    if (tap == TAP_W'(TAPS - 1)) begin
                        state <= FETCH_WAIT;
                    end else begin
                        tap <= tap + 1'b1;
                        if (dx == 2'd2) begin
                            dx <= '0;
                            dy <= dy + 1'b1;
                        end else begin
                            dx <= dx + 1'b1;
                        end
                    end
                end
                FETCH_WAIT: begin           // Last word lands this cycle
                    o_conv_ready <= 1'b1;
                    state        <= FETCH_CONV;
                end
                FETCH_CONV: if (i_conv_valid) state <= FETCH_NEXT;
                FETCH_NEXT: begin
                    dx    <= '0;
                    dy    <= '0;
                    tap   <= '0;
                    state <= FETCH_REQ;
                    if (col == ADDR_W'(IMG_W - 3)) begin
                        col <= '0;
                        if (row == ADDR_W'(IMG_H - 3)) begin
                            o_done <= 1'b1;
                            o_busy <= 1'b0;
                            state  <= FETCH_IDLE;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pend)
            o_window[rd_tap*DATA_W +: DATA_W] <= i_rdata;
    end

endmodule

`default_nettype wire

//--- source/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top #(
    parameter int IMG_W     = 8,
    parameter int IMG_H     = 8,
    parameter int MEM_DEPTH = 128
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_host_req,
    input  logic                        i_host_we,
    input  logic [conv_pkg::ADDR_W-1:0] i_host_addr,
    input  logic [conv_pkg::DATA_W-1:0] i_host_wdata,
    input  logic                        i_start,
    output logic                        o_pix_valid,
    output logic [conv_pkg::DATA_W-1:0] o_pix_data,
    output logic                        o_done,
    output logic                        o_busy
);
    import conv_pkg::*;

    localparam int WEIGHT_BASE = IMG_W * IMG_H;     // Weights follow the image

    logic              wl_req, wl_gnt, wl_busy, loaded;
    logic [ADDR_W-1:0] wl_addr;
    logic              wf_req, wf_gnt, wf_busy, conv_ready;
    logic [ADDR_W-1:0] wf_addr;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata, mem_rdata;
    logic [WIN_W-1:0]  weights, window;

    assign o_busy = wl_busy | wf_busy;

    mem_arbiter u_arb (
        .i_host_req (i_host_req),   .i_host_we    (i_host_we),
        .i_host_addr(i_host_addr),  .i_host_wdata (i_host_wdata),
        .i_wl_req   (wl_req),       .i_wl_addr    (wl_addr),     .o_wl_gnt (wl_gnt),
        .i_wf_req   (wf_req),       .i_wf_addr    (wf_addr),     .o_wf_gnt (wf_gnt),
        .o_mem_we   (mem_we),       .o_mem_addr   (mem_addr),    .o_mem_wdata(mem_wdata)
    );

    pixel_mem #(.MEM_DEPTH(MEM_DEPTH)) u_mem (
        .clk(clk), .i_we(mem_we), .i_addr(mem_addr), .i_wdata(mem_wdata), .o_rdata(mem_rdata)
    );

    // Start is ignored for the whole run
    weight_load #(.WEIGHT_BASE(WEIGHT_BASE)) u_wload (
        .clk     (clk),      .rst_n (rst_n),     .i_start   (i_start & ~o_busy),
        .o_req   (wl_req),   .o_addr(wl_addr),   .i_gnt     (wl_gnt),
        .i_rdata (mem_rdata), .o_weights(weights), .o_loaded(loaded), .o_busy(wl_busy)
    );

    window_fetch #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_wfetch (
        .clk        (clk),        .rst_n  (rst_n),     .i_go        (loaded),
        .o_req      (wf_req),     .o_addr (wf_addr),   .i_gnt       (wf_gnt),
        .i_rdata    (mem_rdata),  .o_window(window),   .o_conv_ready(conv_ready),
        .i_conv_valid(o_pix_valid), .o_done(o_done),   .o_busy      (wf_busy)
    );

    conv_3x3 u_conv (
        .clk         (clk),        .rst_n (rst_n),
        .i_im        (window),     .i_iw  (weights),
        .i_conv_ready(conv_ready), .o_om  (o_pix_data), .o_conv_valid(o_pix_valid)
    );

endmodule

`default_nettype wire

//--- tests/tb_conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv_top;
    import conv_pkg::*;

    localparam int IMG_W          = 8;
    localparam int IMG_H          = 8;
    localparam int OUT_N          = (IMG_W - 2) * (IMG_H - 2);
    localparam int WBASE          = IMG_W * IMG_H;
    localparam int N_TESTS        = 6;
    localparam int TIMEOUT_CYCLES = N_TESTS * (9 + 36 * 40) * 2;

    logic              clk;
    logic              rst_n;
    logic              i_host_req;
    logic              i_host_we;
    logic [ADDR_W-1:0] i_host_addr;
    logic [DATA_W-1:0] i_host_wdata;
    logic              i_start;
    logic              o_pix_valid;
    logic [DATA_W-1:0] o_pix_data;
    logic              o_done;
    logic              o_busy;

    logic [DATA_W-1:0] img [IMG_W*IMG_H];     // Host copy of the image
    logic [DATA_W-1:0] wts [TAPS];
    logic [DATA_W-1:0] exp_q [$];
    logic [DATA_W-1:0] expected;
    logic [31:0]       lfsr_state = 32'h93e4;
    int                errors     = 0;
    int                n_checks   = 0;
    int                n_results  = 0;
    int                n_done     = 0;
    int                cycles     = 0;
    int                run_err0;
    int                run_res0;
    int                run_done0;

    conv_top #(.IMG_W(IMG_W), .IMG_H(IMG_H), .MEM_DEPTH(128)) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_host_req   (i_host_req),
        .i_host_we    (i_host_we),
        .i_host_addr  (i_host_addr),
        .i_host_wdata (i_host_wdata),
        .i_start      (i_start),
        .o_pix_valid  (o_pix_valid),
        .o_pix_data   (o_pix_data),
        .o_done       (o_done),
        .o_busy       (o_busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random bits and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic logic [DATA_W-1:0] sign_extend(input logic [31:0] v, input int n);
        logic [DATA_W-1:0] r;
        r = v[DATA_W-1:0];
        for (int i = n; i < DATA_W; i++)
            r[i] = v[n-1];
        return r;
    endfunction

    function automatic logic [DATA_W-1:0] saturate(input logic signed [33:0] v);
        if (v > 34'sd32767)
            return 16'h7fff;
        if (v < -34'sd32768)
            return 16'h8000;
        return v[DATA_W-1:0];
    endfunction

    function automatic logic [DATA_W-1:0] mul_q88(input logic [DATA_W-1:0] a,
                                                   input logic [DATA_W-1:0] b);
        logic signed [33:0] p;
        logic signed [33:0] q;
        p = $signed(a) * $signed(b);
        q = p / 256;
        if (p < 0 && p % 256 != 0)
            q = q - 1;                  // Floor rather than toward zero
        return saturate(q);
    endfunction

    function automatic logic [DATA_W-1:0] add_q88(input logic [DATA_W-1:0] a,
                                                   input logic [DATA_W-1:0] b);
        logic signed [33:0] s;
        s = $signed(a) + $signed(b);
        return saturate(s);
    endfunction

    // Pairs, sums of pairs, then the ninth product last
    function automatic logic [DATA_W-1:0] conv_ref(input int row, input int col);
        logic [DATA_W-1:0] p [TAPS];
        for (int t = 0; t < TAPS; t++)
            p[t] = mul_q88(img[(row + t / 3) * IMG_W + col + t % 3], wts[t]);
        return add_q88(add_q88(add_q88(add_q88(p[0], p[1]), add_q88(p[2], p[3])),
                               add_q88(add_q88(p[4], p[5]), add_q88(p[6], p[7]))), p[8]);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (rst_n && o_pix_valid) begin
            n_results++;
            n_checks++;
            assert (exp_q.size() > 0) else begin
                $display("Result at %0t arrived with none expected", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                assert (o_pix_data === expected) else begin
                    $display("[ERROR] %0t: result %0d is %h, expected %h", $time,
                             n_results - run_res0, o_pix_data, expected);
                    errors++;
                end
            end
        end
        if (rst_n && o_done)
            n_done++;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host side tasks entered on a falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        i_host_req   = 1'b1;
        i_host_we    = 1'b1;
        i_host_addr  = addr;
        i_host_wdata = data;
        @(negedge clk);
        i_host_req = 1'b0;
        i_host_we  = 1'b0;
    endtask

    task automatic write_weights();
        for (int t = 0; t < TAPS; t++)
            host_write(ADDR_W'(WBASE + t), wts[t]);
    endtask

    task automatic load_memory();
        for (int i = 0; i < IMG_W * IMG_H; i++)
            host_write(ADDR_W'(i), img[i]);
        write_weights();
    endtask

    task automatic start_run();
        run_err0  = errors;
        run_res0  = n_results;
        run_done0 = n_done;
        for (int r = 0; r < IMG_H - 2; r++)
            for (int c = 0; c < IMG_W - 2; c++)
                exp_q.push_back(conv_ref(r, c));
        i_start = 1'b1;
        @(negedge clk);
        i_start = 1'b0;
        n_checks++;
        assert (o_busy) else begin
            $display("Busy did not rise the cycle after start at %0t", $time);
            errors++;
        end
    endtask

    task automatic finish_run(input int num, input string name);
        while (n_done == run_done0)
            @(negedge clk);
        repeat (20) @(negedge clk);     // Room for stray results
        n_checks += 3;
        assert (n_results - run_res0 == OUT_N) else begin
            $display("Test %0d gave %0d results instead of %0d", num,
                     n_results - run_res0, OUT_N);
            errors++;
        end
        assert (n_done - run_done0 == 1) else begin
            $display("Test %0d saw %0d done pulses instead of one", num, n_done - run_done0);
            errors++;
        end
        assert (exp_q.size() == 0 && !o_busy) else begin
            $display("Test %0d ended with results missing or busy still high", num);
            errors++;
        end
        exp_q.delete();
        $display("Test %0d %s: %0d results, %0d errors", num, name,
                 n_results - run_res0, errors - run_err0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst_n        = 1'b0;
        i_host_req   = 1'b0;
        i_host_we    = 1'b0;
        i_host_addr  = '0;
        i_host_wdata = '0;
        i_start      = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        repeat (20) begin
            @(negedge clk);
            n_checks++;
            assert (!o_pix_valid && !o_done && !o_busy) else begin
                $display("Outputs went high without a start at %0t", $time);
                errors++;
            end
        end
        $display("Test 1 reset state: %0d errors", errors);

        for (int i = 0; i < IMG_W * IMG_H; i++)
            img[i] = sign_extend(take_bits(12), 12);
        for (int t = 0; t < TAPS; t++)
            wts[t] = sign_extend(take_bits(9), 9);
        load_memory();
        start_run();
        finish_run(2, "random image");

        // Top half drives the positive limit and bottom half the negative one
        for (int i = 0; i < IMG_W * IMG_H; i++)
            img[i] = (i < WBASE / 2) ? (16'h7000 | 16'(take_bits(8)))
                                     : (16'h8000 | 16'(take_bits(8)));
        for (int t = 0; t < TAPS; t++)
            wts[t] = 16'h7f00 | 16'(take_bits(8));
        load_memory();
        start_run();
        finish_run(3, "saturation");

        for (int i = 0; i < IMG_W * IMG_H; i++)
            img[i] = 16'hfc00 | 16'(take_bits(10));
        for (int t = 0; t < TAPS; t++)
            wts[t] = (take_bits(1) ? 16'hff00 : 16'h0000) | 16'(take_bits(8)) | 16'h0001;
        load_memory();
        start_run();
        finish_run(4, "negative truncation");

        for (int i = 0; i < IMG_W * IMG_H; i++)
            img[i] = sign_extend(take_bits(12), 12);
        for (int t = 0; t < TAPS; t++)
            wts[t] = sign_extend(take_bits(9), 9);
        load_memory();
        start_run();
        for (int k = 0; k < 48; k++) begin
            host_write(ADDR_W'(73 + take_bits(6) % 55), 16'(take_bits(16)));
            repeat (take_bits(3)) @(negedge clk);
            if (k == 10) begin
                // Bank is loaded once results flow
                while (n_results == run_res0)
                    @(negedge clk);
                for (int t = 0; t < TAPS; t++)
                    host_write(ADDR_W'(WBASE + t), ~wts[t]);
                i_start = 1'b1;         // Must not reload the altered weights
                @(negedge clk);
                i_start = 1'b0;
            end
        end
        finish_run(5, "host traffic");

        for (int t = 0; t < TAPS; t++)
            wts[t] = sign_extend(take_bits(9), 9);
        write_weights();
        start_run();
        finish_run(6, "weight reload");

        $display("Tests: %0d, checks: %0d, errors: %0d", N_TESTS, n_checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
source/conv_pkg.sv
source/fx_mult.sv
source/fx_add.sv
source/conv_3x3.sv
source/pixel_mem.sv
source/mem_arbiter.sv
source/weight_load.sv
source/window_fetch.sv
source/conv_top.sv
tests/tb_conv_top.sv

//--- Makefile
TOP = tb_conv_top

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f $(wildcard source/*.sv) tests/tb_conv_top.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f sim.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test passed" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -Wall --top-module conv_top -f sim.f

clean:
	rm -rf obj_dir sim.log
